//--- verilog/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

    // #####################
    // Bus geometry
    // #####################
    parameter int ADDR_W = 16; // Byte address width.
    parameter int DATA_W = 32;
    parameter int OFFS_W = 12; // Offset inside one 4 KiB region.

    // #####################
    // Region bases
    // #####################
    parameter logic [ADDR_W-1:0] CLINT_BASE = 16'h0000;
    parameter logic [ADDR_W-1:0] UART_BASE  = 16'h1000;

    // CLINT word offsets.
    parameter logic [OFFS_W-1:0] CLINT_MSIP        = 12'h000;
    parameter logic [OFFS_W-1:0] CLINT_MTIMECMP_LO = 12'h008;
    parameter logic [OFFS_W-1:0] CLINT_MTIMECMP_HI = 12'h00C;
    parameter logic [OFFS_W-1:0] CLINT_MTIME_LO    = 12'h010;
    parameter logic [OFFS_W-1:0] CLINT_MTIME_HI    = 12'h014;

    // UART word offsets.
    parameter logic [OFFS_W-1:0] UART_TXDATA = 12'h000;
    parameter logic [OFFS_W-1:0] UART_STATUS = 12'h004;
    parameter logic [OFFS_W-1:0] UART_CTRL   = 12'h008;

    parameter logic [DATA_W-1:0] ERR_DATA = 32'hDEAD_BEEF; // Read value of unmapped space.

endpackage

`default_nettype wire

//--- verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // #####################
    // Register layouts
    // #####################
    typedef struct packed {
        logic [14:0] reserved;
        logic        tx_irq_en;
        logic [15:0] divisor;  // Bit time is divisor+1 clocks.
    } uart_ctrl_t;

    typedef struct packed {
        logic [23:0] reserved;
        logic [7:0]  tx_byte;
    } uart_tx_word_t;

    // One bus write word, read as CTRL or as TXDATA by offset.
    typedef union packed {
        uart_ctrl_t    ctrl;
        uart_tx_word_t tx;
    } uart_wdata_u;

    // #####################
    // Status bits
    // #####################
    parameter int STAT_EMPTY = 0;
    parameter int STAT_FULL  = 1;
    parameter int STAT_BUSY  = 2;
    parameter int STAT_COUNT = 8; // LSB of the FIFO occupancy field.

endpackage

`default_nettype wire

//--- verilog/periph_decoder.sv
`default_nettype none

module periph_decoder (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic [soc_map_pkg::ADDR_W-1:0] wb_adr_i,
    output logic [soc_map_pkg::DATA_W-1:0] wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           wb_err_o,
    output logic                           clint_stb_o,
    output logic                           uart_stb_o,
    output logic [soc_map_pkg::OFFS_W-1:0] slv_adr_o,
    input  logic                           clint_ack_i,
    input  logic [soc_map_pkg::DATA_W-1:0] clint_dat_i,
    input  logic                           uart_ack_i,
    input  logic [soc_map_pkg::DATA_W-1:0] uart_dat_i
);
    import soc_map_pkg::*;

    logic req;
    logic clint_hit;
    logic uart_hit;
    logic err_q;

    assign req       = wb_cyc_i & wb_stb_i;
    assign clint_hit = (wb_adr_i[ADDR_W-1:OFFS_W] == CLINT_BASE[ADDR_W-1:OFFS_W]);
    assign uart_hit  = (wb_adr_i[ADDR_W-1:OFFS_W] == UART_BASE[ADDR_W-1:OFFS_W]);

    assign clint_stb_o = req & clint_hit;
    assign uart_stb_o  = req & uart_hit;
    assign slv_adr_o   = wb_adr_i[OFFS_W-1:0];

    always_comb begin
        if (clint_hit) begin
            wb_dat_o = clint_dat_i;
            wb_ack_o = clint_ack_i;
        end else if (uart_hit) begin
            wb_dat_o = uart_dat_i;
            wb_ack_o = uart_ack_i;
        end else begin
            wb_dat_o = ERR_DATA;
            wb_ack_o = 1'b0;
        end
    end

    // Unmapped cycles end with a one-cycle error.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & ~clint_hit & ~uart_hit & ~err_q;
        end
    end

    assign wb_err_o = err_q;

endmodule

`default_nettype wire

//--- verilog/clint_timer.sv
`default_nettype none

module clint_timer (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  logic [soc_map_pkg::OFFS_W-1:0]   adr_i,
    input  logic [soc_map_pkg::DATA_W-1:0]   dat_i,
    input  logic [soc_map_pkg::DATA_W/8-1:0] sel_i,
    output logic [soc_map_pkg::DATA_W-1:0]   dat_o,
    output logic                             ack_o,
    output logic                             timer_irq_o,
    output logic                             soft_irq_o
);
    import soc_map_pkg::*;

    logic        ack_q;
    logic        wr_en;
    logic        msip_q;
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;

    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0]   old_w,
        input logic [DATA_W-1:0]   new_w,
        input logic [DATA_W/8-1:0] sel
    );
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int i = 0; i < DATA_W/8; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign wr_en = stb_i & we_i & ~ack_q; // First cycle of the access.

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q      <= 1'b0;
            msip_q     <= 1'b0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
        end else begin
            ack_q   <= stb_i & ~ack_q;
            mtime_q <= mtime_q + 64'd1;
            if (wr_en) begin
                case (adr_i)
                    CLINT_MSIP: begin
                        if (sel_i[0]) begin
                            msip_q <= dat_i[0];
                        end
                    end
                    CLINT_MTIMECMP_LO: mtimecmp_q[31:0]  <= merge_bytes(mtimecmp_q[31:0], dat_i, sel_i);
                    CLINT_MTIMECMP_HI: mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], dat_i, sel_i);
                    CLINT_MTIME_LO:    mtime_q[31:0]     <= merge_bytes(mtime_q[31:0], dat_i, sel_i);
                    CLINT_MTIME_HI:    mtime_q[63:32]    <= merge_bytes(mtime_q[63:32], dat_i, sel_i);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (adr_i)
            CLINT_MSIP:        dat_o <= {{(DATA_W-1){1'b0}}, msip_q};
            CLINT_MTIMECMP_LO: dat_o <= mtimecmp_q[31:0];
            CLINT_MTIMECMP_HI: dat_o <= mtimecmp_q[63:32];
            CLINT_MTIME_LO:    dat_o <= mtime_q[31:0];
            CLINT_MTIME_HI:    dat_o <= mtime_q[63:32];
            default:           dat_o <= '0;
        endcase
    end

    assign ack_o       = ack_q;
    assign timer_irq_o = (mtime_q >= mtimecmp_q);
    assign soft_irq_o  = msip_q;

endmodule

`default_nettype wire

//--- verilog/uart_regs.sv
`default_nettype none

module uart_regs #(
    parameter int TX_FIFO_DEPTH = 8,
    parameter int RESET_DIVISOR = 16
) (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  logic [soc_map_pkg::OFFS_W-1:0]   adr_i,
    input  logic [soc_map_pkg::DATA_W-1:0]   dat_i,
    output logic [soc_map_pkg::DATA_W-1:0]   dat_o,
    output logic                             ack_o,
    output logic                             push_o,
    output logic [7:0]                       push_byte_o,
    input  logic                             fifo_full_i,
    input  logic                             fifo_empty_i,
    input  logic [$clog2(TX_FIFO_DEPTH):0]   fifo_count_i,
    input  logic                             tx_busy_i,
    output logic [15:0]                      divisor_o,
    output logic                             uart_irq_o
);
    import soc_map_pkg::*;
    import uart_pkg::*;

    localparam int CNT_W = $clog2(TX_FIFO_DEPTH) + 1;

    uart_wdata_u       wdata;
    uart_ctrl_t        ctrl_q;
    logic              ack_q;
    logic              tx_wr;
    logic              ctrl_wr;
    logic [DATA_W-1:0] status;

    assign wdata   = dat_i;
    assign tx_wr   = stb_i & we_i & (adr_i == UART_TXDATA);
    assign ctrl_wr = ack_q & stb_i & we_i & (adr_i == UART_CTRL);

    // #####################
    // Bus handshake
    // #####################
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q  <= 1'b0;
            ctrl_q <= '{divisor: 16'(RESET_DIVISOR), default: '0};
        end else begin
            ack_q <= stb_i & ~ack_q & ~(tx_wr & fifo_full_i); // Hold off while full.
            if (ctrl_wr) begin
                ctrl_q          <= wdata.ctrl;
                ctrl_q.reserved <= '0;
            end
        end
    end

    assign push_o      = ack_q & tx_wr; // Byte enters the FIFO in the ack cycle.
    assign push_byte_o = wdata.tx.tx_byte;

    always_comb begin
        status                          = '0;
        status[STAT_EMPTY]              = fifo_empty_i;
        status[STAT_FULL]               = fifo_full_i;
        status[STAT_BUSY]               = tx_busy_i;
        status[STAT_COUNT +: CNT_W]     = fifo_count_i;
    end

    always_comb begin
        case (adr_i)
            UART_STATUS: dat_o = status;
            UART_CTRL:   dat_o = ctrl_q;
            default:     dat_o = '0;
        endcase
    end

    assign ack_o      = ack_q;
    assign divisor_o  = ctrl_q.divisor;
    assign uart_irq_o = ctrl_q.tx_irq_en & fifo_empty_i & ~tx_busy_i; // Line drained.

endmodule

`default_nettype wire

//--- verilog/uart_tx_fifo.sv
`default_nettype none

module uart_tx_fifo #(
    parameter int TX_FIFO_DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           push_i,
    input  logic [7:0]                     push_byte_i,
    input  logic                           pop_i,
    output logic [7:0]                     head_byte_o,
    output logic                           empty_o,
    output logic                           full_o,
    output logic [$clog2(TX_FIFO_DEPTH):0] count_o
);
    localparam int PTR_W = $clog2(TX_FIFO_DEPTH);

    logic [7:0]       mem [TX_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at a power of two.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count_q <= count_q + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_byte_i;
        end
    end

    assign head_byte_o = mem[rd_ptr];
    assign empty_o     = (count_q == '0);
    assign full_o      = (count_q == (PTR_W+1)'(TX_FIFO_DEPTH));
    assign count_o     = count_q;

endmodule

`default_nettype wire

//--- verilog/uart_tx_serializer.sv
`default_nettype none

module uart_tx_serializer (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        fifo_empty_i,
    input  logic [7:0]  head_byte_i,
    output logic        pop_o,
    input  logic [15:0] divisor_i,
    output logic        busy_o,
    output logic        txd_o
);
    logic        busy_q;
    logic [9:0]  shift_q;  // Stop, data LSB first, start.
    logic [15:0] div_q;
    logic [15:0] baud_cnt;
    logic [3:0]  bit_cnt;
    logic        bit_end;

    assign pop_o   = ~busy_q & ~fifo_empty_i;
    assign bit_end = (baud_cnt == div_q);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else if (pop_o) begin
            busy_q <= 1'b1;
        end else if (busy_q && bit_end && bit_cnt == 4'd9) begin
            busy_q <= 1'b0; // Stop bit done.
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            shift_q  <= '1; // Idle line is high.
            div_q    <= '0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (pop_o) begin
            shift_q  <= {1'b1, head_byte_i, 1'b0};
            div_q    <= divisor_i; // Held for the whole frame.
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (busy_q) begin
            if (bit_end) begin
                shift_q  <= {1'b1, shift_q[9:1]}; // Refills with idle ones.
                baud_cnt <= '0;
                bit_cnt  <= bit_cnt + 4'd1;
            end else begin
                baud_cnt <= baud_cnt + 16'd1;
            end
        end
    end

    assign busy_o = busy_q;
    assign txd_o  = shift_q[0];

endmodule

`default_nettype wire

//--- verilog/periph_soc.sv
`default_nettype none

module periph_soc #(
    parameter int TX_FIFO_DEPTH = 8,
    parameter int RESET_DIVISOR = 16
) (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic [soc_map_pkg::ADDR_W-1:0]   wb_adr_i,
    input  logic [soc_map_pkg::DATA_W-1:0]   wb_dat_i,
    input  logic [soc_map_pkg::DATA_W/8-1:0] wb_sel_i,
    output logic [soc_map_pkg::DATA_W-1:0]   wb_dat_o,
    output logic                             wb_ack_o,
    output logic                             wb_err_o,
    output logic                             txd_o,
    output logic                             timer_irq_o,
    output logic                             soft_irq_o,
    output logic                             uart_irq_o
);
    import soc_map_pkg::*;

    localparam int CNT_W = $clog2(TX_FIFO_DEPTH) + 1;

    logic              clint_stb;
    logic              uart_stb;
    logic [OFFS_W-1:0] slv_adr;
    logic              clint_ack;
    logic [DATA_W-1:0] clint_dat;
    logic              uart_ack;
    logic [DATA_W-1:0] uart_dat;
    logic              push;
    logic [7:0]        push_byte;
    logic              pop;
    logic [7:0]        head_byte;
    logic              fifo_full;
    logic              fifo_empty;
    logic [CNT_W-1:0]  fifo_count;
    logic              tx_busy;
    logic [15:0]       divisor;

    // #####################
    // Bus routing
    // #####################
    periph_decoder i_decoder (
        .clk(clk), .rst_i(rst_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_adr_i(wb_adr_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
        .clint_stb_o(clint_stb), .uart_stb_o(uart_stb), .slv_adr_o(slv_adr),
        .clint_ack_i(clint_ack), .clint_dat_i(clint_dat),
        .uart_ack_i(uart_ack), .uart_dat_i(uart_dat)
    );

    clint_timer i_clint (
        .clk(clk), .rst_i(rst_i),
        .stb_i(clint_stb), .we_i(wb_we_i), .adr_i(slv_adr),
        .dat_i(wb_dat_i), .sel_i(wb_sel_i), .dat_o(clint_dat), .ack_o(clint_ack),
        .timer_irq_o(timer_irq_o), .soft_irq_o(soft_irq_o)
    );

    // #####################
    // UART chain
    // #####################
    uart_regs #(
        .TX_FIFO_DEPTH(TX_FIFO_DEPTH),
        .RESET_DIVISOR(RESET_DIVISOR)
    ) i_uart_regs (
        .clk(clk), .rst_i(rst_i),
        .stb_i(uart_stb), .we_i(wb_we_i), .adr_i(slv_adr),
        .dat_i(wb_dat_i), .dat_o(uart_dat), .ack_o(uart_ack),
        .push_o(push), .push_byte_o(push_byte),
        .fifo_full_i(fifo_full), .fifo_empty_i(fifo_empty), .fifo_count_i(fifo_count),
        .tx_busy_i(tx_busy), .divisor_o(divisor), .uart_irq_o(uart_irq_o)
    );

    uart_tx_fifo #(
        .TX_FIFO_DEPTH(TX_FIFO_DEPTH)
    ) i_tx_fifo (
        .clk(clk), .rst_i(rst_i),
        .push_i(push), .push_byte_i(push_byte), .pop_i(pop),
        .head_byte_o(head_byte), .empty_o(fifo_empty), .full_o(fifo_full),
        .count_o(fifo_count)
    );

    uart_tx_serializer i_tx_ser (
        .clk(clk), .rst_i(rst_i),
        .fifo_empty_i(fifo_empty), .head_byte_i(head_byte), .pop_o(pop),
        .divisor_i(divisor), .busy_o(tx_busy), .txd_o(txd_o)
    );

endmodule

`default_nettype wire

//--- verif/periph_soc_props.sv
`default_nettype none

module periph_soc_props (
    input logic clk,
    input logic rst_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic wb_err_i,
    input logic tx_busy_i,
    input logic txd_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // ####################
    // Wishbone handshake
    // ####################
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst_i)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else $error("ack outside an active cycle");

    ack_err_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(wb_ack_i && wb_err_i))
        else $error("ack and err high together");

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst_i)
        wb_ack_i |=> !wb_ack_i)
        else $error("ack held longer than one cycle");

    // Serial line.
    txd_idle_high: assert property (@(posedge clk) disable iff (rst_i)
        !tx_busy_i |-> txd_i)
        else $error("txd low while the serializer is idle");

endmodule

bind periph_soc periph_soc_props i_props (
    .clk(clk), .rst_i(rst_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_ack_i(wb_ack_o), .wb_err_i(wb_err_o),
    .tx_busy_i(tx_busy), .txd_i(txd_o)
);

`default_nettype wire

//--- verif/periph_soc_tb.sv
`default_nettype none

module periph_soc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import soc_map_pkg::*;
    import uart_pkg::*;

    localparam int DEPTH     = 8;
    localparam int RESET_DIV = 16;
    localparam int CNT_W     = $clog2(DEPTH) + 1;
    localparam int N_BYTES   = 20 + DEPTH + 4 + 3; // Bytes sent over the whole run.
    localparam int N_BUS     = 80;                 // Bus cycles besides the drain polls.
    localparam int MAX_BIT   = 10;                 // Slowest bit time, in clocks.
    localparam int MAX_DELTA = 64 + 255;
    localparam int LIMIT     = 2 * (N_BYTES * 10 * MAX_BIT + N_BUS * 4 + MAX_DELTA) + 16;

    localparam logic [15:0] A_MSIP     = {CLINT_BASE[15:12], CLINT_MSIP};
    localparam logic [15:0] A_CMP_LO   = {CLINT_BASE[15:12], CLINT_MTIMECMP_LO};
    localparam logic [15:0] A_CMP_HI   = {CLINT_BASE[15:12], CLINT_MTIMECMP_HI};
    localparam logic [15:0] A_MTIME_LO = {CLINT_BASE[15:12], CLINT_MTIME_LO};
    localparam logic [15:0] A_TXDATA   = {UART_BASE[15:12], UART_TXDATA};
    localparam logic [15:0] A_STATUS   = {UART_BASE[15:12], UART_STATUS};
    localparam logic [15:0] A_CTRL     = {UART_BASE[15:12], UART_CTRL};
    localparam logic [15:0] A_UNMAPPED = 16'h2000;

    logic        clk = 1'b0;
    logic        rst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [15:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        wb_err_o;
    logic        txd_o;
    logic        timer_irq_o;
    logic        soft_irq_o;
    logic        uart_irq_o;

    logic        msip_sh;   // Shadows of the written registers.
    logic [63:0] cmp_sh;
    logic [31:0] ctrl_sh;
    logic [15:0] tb_div;
    logic [31:0] lfsr_q;
    logic [7:0]  exp_q[$];
    logic [7:0]  rx_q[$];
    int          errors   = 0;
    int          rx_count = 0;
    int          saw_full = 0;

    periph_soc #(
        .TX_FIFO_DEPTH(DEPTH),
        .RESET_DIVISOR(RESET_DIV)
    ) i_dut (
        .clk(clk), .rst_i(rst_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
        .txd_o(txd_o), .timer_irq_o(timer_irq_o), .soft_irq_o(soft_irq_o),
        .uart_irq_o(uart_irq_o)
    );

    always #10 clk = ~clk;

    // ####################
    // Helpers
    // ####################
    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [31:0] expected_read(input logic [15:0] adr);
        logic [31:0] r;
        r = ERR_DATA;
        if (adr[15:12] == CLINT_BASE[15:12]) begin
            case (adr[11:0])
                CLINT_MSIP:        r = {31'd0, msip_sh};
                CLINT_MTIMECMP_LO: r = cmp_sh[31:0];
                CLINT_MTIMECMP_HI: r = cmp_sh[63:32];
                default:           r = 32'd0;
            endcase
        end else if (adr[15:12] == UART_BASE[15:12]) begin
            r = (adr[11:0] == UART_CTRL) ? ctrl_sh : 32'd0;
        end
        return r;
    endfunction

    task automatic bus_cycle(
        input  logic        we,
        input  logic [15:0] adr,
        input  logic [31:0] dat,
        input  logic [3:0]  sel,
        output logic [31:0] rdat,
        output logic        err
    );
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_sel_i <= sel;
        do begin
            @(negedge clk);
        end while (!(wb_ack_o || wb_err_o));
        rdat = wb_dat_o;
        err  = wb_err_o;
        @(posedge clk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] rd;
        logic        err;
        int          off;
        bus_cycle(1'b1, adr, dat, sel, rd, err);
        check_true(!err, "Write was answered with a bus error");
        off = (adr == A_CMP_HI) ? 32 : 0;
        case (adr)
            A_MSIP: begin
                if (sel[0]) begin
                    msip_sh = dat[0];
                end
            end
            A_CMP_LO, A_CMP_HI: begin
                for (int i = 0; i < 4; i++) begin
                    if (sel[i]) begin
                        cmp_sh[off + 8*i +: 8] = dat[8*i +: 8];
                    end
                end
            end
            A_CTRL:  ctrl_sh = {15'd0, dat[16:0]}; // Reserved bits read as zero.
            default: ;
        endcase
    endtask

    task automatic read_reg(input logic [15:0] adr, output logic [31:0] data);
        logic err;
        bus_cycle(1'b0, adr, 32'd0, 4'hF, data, err);
        check_true(!err, "Read was answered with a bus error");
    endtask

    task automatic read_check(input logic [15:0] adr);
        logic [31:0] rd;
        read_reg(adr, rd);
        check_eq(rd, expected_read(adr), $sformatf("readback of %h", adr));
    endtask

    task automatic set_ctrl(input logic [15:0] div, input logic irq_en);
        write_reg(A_CTRL, {15'd0, irq_en, div}, 4'hF);
        tb_div = div;
    endtask

    task automatic send_byte();
        logic [31:0] r;
        rand_bits(8, r);
        write_reg(A_TXDATA, {24'd0, r[7:0]}, 4'hF);
        exp_q.push_back(r[7:0]);
    endtask

    // Polls STATUS until the FIFO is empty and the line is idle.
    task automatic wait_drained();
        logic [31:0] st;
        do begin
            read_reg(A_STATUS, st);
            if (st[STAT_FULL]) begin
                saw_full++;
                check_eq(32'(st[STAT_COUNT +: CNT_W]), DEPTH, "FIFO count while full");
            end
        end while (!(st[STAT_EMPTY] && !st[STAT_BUSY]));
        check_eq(32'(st[STAT_COUNT +: CNT_W]), 32'd0, "FIFO count after drain");
        @(negedge clk);
        check_true(exp_q.size() == 0 && rx_q.size() == 0, "Written bytes never left the line");
    endtask

    // ####################
    // Line monitor
    // ####################
    always begin : line_monitor
        int         bit_clks;
        logic [7:0] rx_b;
        @(negedge clk);
        if (!rst_i && txd_o === 1'b0) begin
            bit_clks = int'(tb_div) + 1;
            repeat (bit_clks / 2) @(negedge clk); // Middle of the start bit.
            check_eq(32'(txd_o), 32'd0, "start bit");
            for (int i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge clk);
                rx_b[i] = txd_o;
            end
            repeat (bit_clks) @(negedge clk);
            check_eq(32'(txd_o), 32'd1, "stop bit");
            rx_q.push_back(rx_b);
        end
    end

    always @(negedge clk) begin : compare_bytes
        logic [7:0] got_b;
        if (rx_q.size() != 0) begin
            got_b = rx_q.pop_front();
            rx_count++;
            if (exp_q.size() == 0) begin
                check_true(1'b0, "Line carried a byte that was never written");
            end else begin
                check_eq(32'(got_b), 32'(exp_q.pop_front()), "UART byte");
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        $display("Regression failed");
        $finish;
    end

    // ####################
    // Test sequence
    // ####################
    initial begin : main
        logic [31:0] r;
        logic [31:0] t0;
        logic [31:0] t1;
        logic        err;
        rst_i    = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        msip_sh  = 1'b0;
        cmp_sh   = '1;
        ctrl_sh  = {16'd0, 16'(RESET_DIV)};
        tb_div   = 16'(RESET_DIV);
        lfsr_q   = 32'h9d65;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;

        // Register readback, reset values first.
        read_check(A_CMP_LO);
        read_check(A_CMP_HI);
        read_check(A_MSIP);
        read_check(A_CTRL);
        write_reg(A_MSIP, 32'h1, 4'h1);
        read_check(A_MSIP);
        rand_bits(32, r);
        write_reg(A_CMP_LO, r, 4'b0101);
        read_check(A_CMP_LO);
        rand_bits(32, r);
        write_reg(A_CMP_HI, r, 4'b1010);
        read_check(A_CMP_HI);
        set_ctrl(16'd4, 1'b0);
        read_check(A_CTRL);

        // Timer and software interrupt.
        @(negedge clk);
        check_eq(32'(soft_irq_o), 32'd1, "soft_irq_o with msip set");
        write_reg(A_MSIP, 32'h0, 4'h1);
        @(negedge clk);
        check_eq(32'(soft_irq_o), 32'd0, "soft_irq_o with msip clear");
        read_reg(A_MTIME_LO, t0);
        read_reg(A_MTIME_LO, t1);
        check_true(t1 > t0, "mtime did not advance between two reads");
        rand_bits(8, r);
        write_reg(A_CMP_HI, 32'hFFFF_FFFF, 4'hF);
        write_reg(A_CMP_LO, t1 + 32'd64 + r, 4'hF);
        write_reg(A_CMP_HI, 32'h0, 4'hF);
        @(negedge clk);
        check_eq(32'(timer_irq_o), 32'd0, "timer_irq_o before the deadline");
        do begin
            @(negedge clk);
        end while (timer_irq_o !== 1'b1);
        read_reg(A_MTIME_LO, t0);
        check_true(t0 >= cmp_sh[31:0], "Timer interrupt rose before mtime reached mtimecmp");
        write_reg(A_CMP_HI, 32'hFFFF_FFFF, 4'hF);
        write_reg(A_CMP_LO, 32'hFFFF_FFFF, 4'hF);
        @(negedge clk);
        check_eq(32'(timer_irq_o), 32'd0, "timer_irq_o after mtimecmp set to all ones");

        // Transmission at two divisors.
        repeat (10) send_byte();
        wait_drained();
        set_ctrl(16'd9, 1'b0);
        repeat (10) send_byte();
        wait_drained();

        // Back-pressure with a short bit time.
        set_ctrl(16'd3, 1'b0);
        saw_full = 0;
        repeat (DEPTH + 4) send_byte();
        wait_drained();
        check_true(saw_full > 0, "FIFO full was never seen during back-pressure");

        // UART interrupt, then an unmapped access.
        set_ctrl(16'd4, 1'b1);
        @(negedge clk);
        check_eq(32'(uart_irq_o), 32'd1, "uart_irq_o on an idle line");
        repeat (3) send_byte();
        @(negedge clk);
        check_eq(32'(uart_irq_o), 32'd0, "uart_irq_o while sending");
        do begin
            @(negedge clk);
        end while (uart_irq_o !== 1'b1);
        check_true(exp_q.size() == 0 && rx_q.size() == 0,
                   "UART interrupt rose before the last frame ended");
        check_eq(32'(txd_o), 32'd1, "txd_o when the interrupt rises");
        bus_cycle(1'b0, A_UNMAPPED, 32'd0, 4'hF, r, err);
        check_eq(32'(err), 32'd1, "wb_err_o on unmapped read");
        check_eq(r, expected_read(A_UNMAPPED), "unmapped read data");
        bus_cycle(1'b1, A_UNMAPPED, 32'h1234_5678, 4'hF, r, err);
        check_eq(32'(err), 32'd1, "wb_err_o on unmapped write");

        $display("Checks done: %0d errors, %0d bytes received", errors, rx_count);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
verilog/soc_map_pkg.sv
verilog/uart_pkg.sv
verilog/periph_decoder.sv
verilog/clint_timer.sv
verilog/uart_regs.sv
verilog/uart_tx_fifo.sv
verilog/uart_tx_serializer.sv
verilog/periph_soc.sv
verif/periph_soc_props.sv
verif/periph_soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module periph_soc_tb -Mdir obj_dir -o periph_soc_sim \
    -f sim.f > "$LOG" 2>&1 &&
    ./obj_dir/periph_soc_sim >> "$LOG" 2>&1

grep -q "^Regression passed$" "$LOG" && echo "Simulation passed" || {
    echo "Simulation failed, see $LOG"
    exit 1
}
